// ==== Bender.yml ====
package:
  name: sdr_bus

sources:
  - source/sdr_bus_pkg.sv
  - source/bus_step_counter.sv
  - source/bus_cmd_fsm.sv
  - source/radio_param_regs.sv
  - source/adc_peak_tracker.sv
  - source/iq_exchange.sv
  - source/sdr_bus_top.sv
  - target: test
    files:
      - dv/sdr_bus_tb.sv

// ==== dv/sdr_bus_tb.sv ====
module sdr_bus_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TESTS  = 13;
	localparam int WAIT_LIMIT = 20; // Cycles

	typedef struct packed
	{
		logic [7:0]      cmd;
		logic [3:0]      n_bytes;   // Data bytes or flash slots
		logic [7:0]      n_samples; // ADC samples strobed before the command
		logic [1:0]      otr;       // dac_otr, adc_otr
		logic [7:0]      busy;      // Flash busy per slot
		logic [0:7][7:0] din;
		logic [0:7][7:0] dout;
	} entry_t;

	logic                    IQ_valid = 1'b0;
	logic                    ADC_MINMAX_RESET;
	logic                    bus_sync;
	logic [7:0]              bus_in;
	logic [7:0]              bus_out;
	logic                    bus_oe;
	sdr_bus_pkg::iq_pair_t   spec_iq;
	sdr_bus_pkg::iq_pair_t   voice_iq;
	logic signed [15:0]      adc_sample;
	logic                    adc_strobe;
	logic                    adc_otr;
	logic                    dac_otr;
	logic [7:0]              flash_data_in;
	logic                    flash_busy;
	sdr_bus_pkg::radio_cfg_t radio_cfg;
	sdr_bus_pkg::iq_pair_t   tx_iq;
	logic                    audio_clk_en;
	logic [7:0]              flash_cmd_byte;
	logic                    flash_enable;
	logic                    flash_continue_read;

	entry_t                tests [NUM_TESTS];
	string                 names [NUM_TESTS];
	string                 cur_name;
	logic [31:0]           lfsr = 32'h3c7aca2e;
	logic signed [15:0]    model_min;
	logic signed [15:0]    model_max;
	logic                  audio_model;
	sdr_bus_pkg::iq_pair_t tx_model;
	int                    checks;
	int                    errors;
	int                    timeouts;

	always #2 IQ_valid = ~IQ_valid;

	sdr_bus_top u_dut (.*);

	// Galois LFSR stepped once per bit
	function automatic logic next_bit();
		logic out_bit;
		out_bit = lfsr[0];
		lfsr = lfsr >> 1;
		if (out_bit)
		begin
			lfsr = lfsr ^ 32'hD0000001;
		end
		return out_bit;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < n; k++)
		begin
			value = {value[30:0], next_bit()};
		end
		return value;
	endfunction

	function automatic entry_t make_entry(input logic [7:0] cmd, input logic [3:0] n_bytes,
		input logic [7:0] n_samples, input logic [1:0] otr, input logic [7:0] busy,
		input logic [63:0] din, input logic [63:0] dout);
		entry_t e;
		e.cmd       = cmd;
		e.n_bytes   = n_bytes;
		e.n_samples = n_samples;
		e.otr       = otr;
		e.busy      = busy;
		e.din       = din;
		e.dout      = dout;
		return e;
	endfunction

	task automatic compare(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("mismatch %s %s: expected %0h actual %0h", cur_name, what, expected, actual);
		end
	endtask

	task automatic send_sync(input logic [7:0] code);
		@(posedge IQ_valid);
		bus_sync <= 1'b1;
		bus_in   <= code;
		@(posedge IQ_valid); // Sync edge
		bus_sync <= 1'b0;
		bus_in   <= 8'h00;
	endtask

	// 12 bit samples so some land inside the start window
	task automatic strobe_samples(input int count);
		logic [31:0]        raw;
		logic signed [15:0] s;
		for (int k = 0; k < count; k++)
		begin
			@(posedge IQ_valid);
			raw = random_bits(12);
			s   = {{4{raw[11]}}, raw[11:0]};
			if (s < model_min)
			begin
				model_min = s;
			end
			if (s > model_max)
			begin
				model_max = s;
			end
			adc_sample <= s;
			adc_strobe <= 1'b1;
		end
		@(posedge IQ_valid);
		adc_strobe <= 1'b0;
	endtask

	task automatic wait_bus_oe();
		int n;
		n = 0;
		@(negedge IQ_valid);
		while (!bus_oe && n < WAIT_LIMIT)
		begin
			@(negedge IQ_valid);
			n++;
		end
		assert (bus_oe)
		else
		begin
			timeouts++;
			$display("timeout in %s: bus_oe stayed low for %0d cycles", cur_name, WAIT_LIMIT);
		end
	endtask

	task automatic wait_flash_pulse();
		int n;
		n = 0;
		@(negedge IQ_valid);
		while (!flash_continue_read && n < WAIT_LIMIT)
		begin
			@(negedge IQ_valid);
			n++;
		end
		assert (flash_continue_read)
		else
		begin
			timeouts++;
			$display("timeout in %s: flash_continue_read never pulsed", cur_name);
		end
	endtask

	task automatic write_bytes(input entry_t e, input logic watch_tx);
		bus_in <= e.din[0];
		for (int k = 0; k < e.n_bytes; k++)
		begin
			@(posedge IQ_valid); // Byte k taken here
			bus_in <= 8'h00;
			if (k + 1 < e.n_bytes)
			begin
				bus_in <= e.din[k + 1];
			end
			if (watch_tx && k + 1 < e.n_bytes)
			begin
				@(negedge IQ_valid);
				compare($sformatf("tx_iq before byte %0d", k + 1), tx_model, tx_iq);
			end
		end
	endtask

	task automatic echo_test(input entry_t e);
		send_sync(e.cmd);
		write_bytes(e, 1'b0);
		wait_bus_oe();
		compare("echo byte", e.dout[0], bus_out);
		compare("flash_enable", 1'b0, flash_enable);
		@(posedge IQ_valid);
		bus_in <= ~e.din[0];
		@(posedge IQ_valid);
		@(negedge IQ_valid);
		compare("echo hold", e.dout[0], bus_out);
		compare("bus_oe hold", 1'b1, bus_oe);
	endtask

	task automatic load_params(input entry_t e);
		sdr_bus_pkg::radio_cfg_t exp_cfg;
		exp_cfg.pga         = e.din[0][5];
		exp_cfg.rand_en     = e.din[0][4];
		exp_cfg.shdn        = e.din[0][3];
		exp_cfg.dith        = e.din[0][2];
		exp_cfg.preamp      = e.din[0][1];
		exp_cfg.tx          = e.din[0][0];
		exp_cfg.freq        = {e.din[1][5:0], e.din[2], e.din[3]};
		exp_cfg.cic_gain    = e.din[4];
		exp_cfg.cicfir_gain = e.din[5];
		send_sync(e.cmd);
		write_bytes(e, 1'b0);
		@(negedge IQ_valid);
		compare("radio_cfg", exp_cfg, radio_cfg);
	endtask

	// Audio commands and unknown codes
	task automatic short_command(input entry_t e);
		if (e.cmd == sdr_bus_pkg::CMD_AUDIO_ON)
		begin
			audio_model = 1'b1;
		end
		else if (e.cmd == sdr_bus_pkg::CMD_AUDIO_OFF)
		begin
			audio_model = 1'b0;
		end
		send_sync(e.cmd);
		@(negedge IQ_valid);
		compare("audio_clk_en", audio_model, audio_clk_en);
		compare("bus_oe", 1'b0, bus_oe);
		compare("flash_enable", 1'b0, flash_enable);
	endtask

	task automatic write_tx_iq(input entry_t e);
		sdr_bus_pkg::iq_pair_t exp_tx;
		exp_tx.q = {e.din[0], e.din[1]};
		exp_tx.i = {e.din[2], e.din[3]};
		send_sync(e.cmd);
		write_bytes(e, 1'b1);
		@(negedge IQ_valid);
		compare("tx_iq", exp_tx, tx_iq);
		tx_model = exp_tx;
	endtask

	task automatic read_rx_iq(input entry_t e);
		sdr_bus_pkg::iq_pair_t spec_p;
		sdr_bus_pkg::iq_pair_t voice_p;
		logic [63:0]           exp_bytes;
		spec_p.q  = 16'(random_bits(16));
		spec_p.i  = 16'(random_bits(16));
		voice_p.q = 16'(random_bits(16));
		voice_p.i = 16'(random_bits(16));
		exp_bytes = {spec_p.q, spec_p.i, voice_p.q, voice_p.i};
		spec_iq  <= spec_p;
		voice_iq <= voice_p;
		send_sync(e.cmd);
		spec_iq  <= ~spec_p; // Must not reach the bus
		voice_iq <= ~voice_p;
		wait_bus_oe();
		for (int k = 0; k < e.n_bytes; k++)
		begin
			@(negedge IQ_valid);
			compare($sformatf("rx_iq byte %0d", k), exp_bytes[63 - 8 * k -: 8], bus_out);
		end
	endtask

	task automatic read_status(input entry_t e);
		logic [0:4][7:0] exp_b;
		exp_b = {6'd0, e.otr, model_min, model_max};
		adc_otr <= e.otr[0];
		dac_otr <= e.otr[1];
		send_sync(e.cmd);
		wait_bus_oe();
		for (int k = 0; k < e.n_bytes; k++)
		begin
			@(negedge IQ_valid);
			compare($sformatf("status byte %0d", k), exp_b[k], bus_out);
		end
		model_min = 16'sd2000; // Window restarts after readback
		model_max = -16'sd2000;
	endtask

	task automatic relay_flash(input entry_t e);
		logic [7:0] exp_b;
		send_sync(e.cmd);
		bus_in <= e.din[0];
		@(negedge IQ_valid);
		compare("flash_enable before command byte", 1'b0, flash_enable);
		@(posedge IQ_valid);
		bus_in        <= 8'h00;
		flash_busy    <= e.busy[0];
		flash_data_in <= e.dout[0];
		@(negedge IQ_valid);
		compare("flash_cmd_byte", e.din[0], flash_cmd_byte);
		compare("flash_enable", 1'b1, flash_enable);
		for (int j = 0; j < e.n_bytes; j++)
		begin
			exp_b = e.busy[j] ? 8'hFF : e.dout[j];
			@(posedge IQ_valid); // Odd step loads a byte
			flash_busy    <= 1'b0;
			flash_data_in <= ~e.dout[j];
			if (e.busy[j])
			begin
				@(negedge IQ_valid);
				compare("flash_continue_read while busy", 1'b0, flash_continue_read);
			end
			else
			begin
				wait_flash_pulse();
			end
			compare($sformatf("flash byte %0d", j), exp_b, bus_out);
			compare("bus_oe during relay", 1'b1, bus_oe);
			@(posedge IQ_valid); // Even step holds
			if (j + 1 < e.n_bytes)
			begin
				flash_busy    <= e.busy[j + 1];
				flash_data_in <= e.dout[j + 1];
			end
			@(negedge IQ_valid);
			compare($sformatf("flash byte %0d hold", j), exp_b, bus_out);
			compare("flash_continue_read width", 1'b0, flash_continue_read);
		end
	endtask

	initial
	begin
		checks      = 0;
		errors      = 0;
		timeouts    = 0;
		audio_model = 1'b1;
		tx_model    = '0;
		model_min   = 16'sd2000;
		model_max   = -16'sd2000;

		ADC_MINMAX_RESET <= 1'b1;
		bus_sync         <= 1'b0;
		bus_in           <= 8'h00;
		spec_iq          <= '0;
		voice_iq         <= '0;
		adc_sample       <= '0;
		adc_strobe       <= 1'b0;
		adc_otr          <= 1'b0;
		dac_otr          <= 1'b0;
		flash_data_in    <= 8'h00;
		flash_busy       <= 1'b0;

		tests[0]  = make_entry(sdr_bus_pkg::CMD_BUS_TEST, 4'd1, 8'd0, 2'b00, 8'h00,
			64'hA500_0000_0000_0000, 64'hA500_0000_0000_0000);
		names[0]  = "echo_reset";
		tests[1]  = make_entry(sdr_bus_pkg::CMD_GET_PARAMS, 4'd6, 8'd3, 2'b00, 8'h00,
			64'h2BC7_1234_5566_0000, 64'h0);
		names[1]  = "param_load";
		tests[2]  = make_entry(sdr_bus_pkg::CMD_AUDIO_OFF, 4'd0, 8'd0, 2'b00, 8'h00, 64'h0, 64'h0);
		names[2]  = "audio_off";
		tests[3]  = make_entry(sdr_bus_pkg::CMD_AUDIO_ON, 4'd0, 8'd0, 2'b00, 8'h00, 64'h0, 64'h0);
		names[3]  = "audio_on";
		tests[4]  = make_entry(sdr_bus_pkg::CMD_TX_IQ, 4'd4, 8'd0, 2'b00, 8'h00,
			64'h8102_7FFE_0000_0000, 64'h0);
		names[4]  = "tx_iq_load";
		tests[5]  = make_entry(sdr_bus_pkg::CMD_RX_IQ, 4'd8, 8'd5, 2'b00, 8'h00, 64'h0, 64'h0);
		names[5]  = "rx_iq_read";
		tests[6]  = make_entry(sdr_bus_pkg::CMD_SEND_STATUS, 4'd5, 8'd24, 2'b01, 8'h00,
			64'h0, 64'h0);
		names[6]  = "status_first";
		tests[7]  = make_entry(sdr_bus_pkg::CMD_SEND_STATUS, 4'd5, 8'd0, 2'b10, 8'h00,
			64'h0, 64'h0);
		names[7]  = "status_rearm";
		tests[8]  = make_entry(sdr_bus_pkg::CMD_SEND_STATUS, 4'd5, 8'd9, 2'b11, 8'h00,
			64'h0, 64'h0);
		names[8]  = "status_window";
		tests[9]  = make_entry(sdr_bus_pkg::CMD_FLASH_READ, 4'd4, 8'd0, 2'b00, 8'b0000_0101,
			64'h0B00_0000_0000_0000, 64'h3D91_E408_0000_0000);
		names[9]  = "flash_relay";
		tests[10] = make_entry(sdr_bus_pkg::CMD_BUS_TEST, 4'd1, 8'd0, 2'b00, 8'h00,
			64'h3C00_0000_0000_0000, 64'h3C00_0000_0000_0000);
		names[10] = "echo_after_flash";
		tests[11] = make_entry(8'h5A, 4'd0, 8'd0, 2'b00, 8'h00, 64'h0, 64'h0);
		names[11] = "unknown_code";
		tests[12] = make_entry(sdr_bus_pkg::CMD_TX_IQ, 4'd4, 8'd2, 2'b00, 8'h00,
			64'h0123_F00D_0000_0000, 64'h0);
		names[12] = "tx_iq_reload";

		repeat (2) @(posedge IQ_valid);
		ADC_MINMAX_RESET <= 1'b0;
		cur_name = "reset_values";
		@(negedge IQ_valid);
		compare("radio_cfg", {6'b0, 22'd242347, 8'd32, 8'd32}, radio_cfg);
		compare("bus_out", 8'h00, bus_out);
		compare("bus_oe", 1'b0, bus_oe);
		compare("tx_iq", 32'h0, tx_iq);
		compare("audio_clk_en", 1'b1, audio_clk_en);
		compare("flash_enable", 1'b0, flash_enable);
		compare("flash_continue_read", 1'b0, flash_continue_read);

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			cur_name = names[t];
			strobe_samples(tests[t].n_samples);
			case (tests[t].cmd)
				sdr_bus_pkg::CMD_BUS_TEST:    echo_test(tests[t]);
				sdr_bus_pkg::CMD_GET_PARAMS:  load_params(tests[t]);
				sdr_bus_pkg::CMD_SEND_STATUS: read_status(tests[t]);
				sdr_bus_pkg::CMD_TX_IQ:       write_tx_iq(tests[t]);
				sdr_bus_pkg::CMD_RX_IQ:       read_rx_iq(tests[t]);
				sdr_bus_pkg::CMD_FLASH_READ:  relay_flash(tests[t]);
				default:                      short_command(tests[t]);
			endcase
		end

		$display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
source/sdr_bus_pkg.sv
source/bus_step_counter.sv
source/bus_cmd_fsm.sv
source/radio_param_regs.sv
source/adc_peak_tracker.sv
source/iq_exchange.sv
source/sdr_bus_top.sv
dv/sdr_bus_tb.sv

// ==== source/adc_peak_tracker.sv ====
module adc_peak_tracker
(
	input  logic                           IQ_valid,
	input  logic                           ADC_MINMAX_RESET,
	input  logic signed [15:0]             adc_sample,
	input  logic                           adc_strobe,
	input  logic                           adc_otr,
	input  logic                           dac_otr,
	input  logic                           status_rd,
	input  logic [sdr_bus_pkg::STEP_W-1:0] step,
	output logic [7:0]                     status_byte
);

	logic signed [15:0] adc_min;
	logic signed [15:0] adc_max;
	logic signed [15:0] snap_min;
	logic signed [15:0] snap_max;
	logic signed [15:0] min_base;
	logic signed [15:0] max_base;
	logic               rd_q;
	logic               snap;
	logic               rearm;

	assign snap  = status_rd && !rd_q; // Sync edge of a status read
	assign rearm = status_rd && rd_q && step == sdr_bus_pkg::STATUS_BYTES - 1'b1;

	// Sample on the rearm edge already counts toward the new window
	assign min_base = rearm ? sdr_bus_pkg::PEAK_MIN_INIT : adc_min;
	assign max_base = rearm ? sdr_bus_pkg::PEAK_MAX_INIT : adc_max;

	always_ff @(posedge IQ_valid)
	begin
		if (ADC_MINMAX_RESET)
		begin
			adc_min <= sdr_bus_pkg::PEAK_MIN_INIT;
			adc_max <= sdr_bus_pkg::PEAK_MAX_INIT;
			rd_q    <= 1'b0;
		end
		else
		begin
			rd_q    <= status_rd;
			adc_min <= (adc_strobe && adc_sample < min_base) ? adc_sample : min_base;
			adc_max <= (adc_strobe && adc_sample > max_base) ? adc_sample : max_base;
		end
	end

	always_ff @(posedge IQ_valid)
	begin
		if (snap)
		begin
			snap_min <= adc_min;
			snap_max <= adc_max;
		end
	end

	always_comb
	begin
		case (step)
			4'd0:    status_byte = {6'd0, dac_otr, adc_otr};
			4'd1:    status_byte = snap_min[15:8];
			4'd2:    status_byte = snap_min[7:0];
			4'd3:    status_byte = snap_max[15:8];
			4'd4:    status_byte = snap_max[7:0];
			default: status_byte = '0;
		endcase
	end

endmodule

// ==== source/bus_cmd_fsm.sv ====
module bus_cmd_fsm
(
	input  logic                           IQ_valid,
	input  logic                           ADC_MINMAX_RESET,
	input  logic                           bus_sync,
	input  logic [7:0]                     bus_in,
	input  logic [sdr_bus_pkg::STEP_W-1:0] step,
	input  logic [7:0]                     iq_byte,
	input  logic [7:0]                     status_byte,
	input  logic [7:0]                     flash_data_in,
	input  logic                           flash_busy,
	output logic                           step_clear,
	output logic                           param_wr,
	output logic                           iq_wr,
	output logic                           iq_rd,
	output logic                           status_rd,
	output logic [7:0]                     bus_out,
	output logic                           bus_oe,
	output logic                           audio_clk_en,
	output logic [7:0]                     flash_cmd_byte,
	output logic                           flash_enable,
	output logic                           flash_continue_read
);

	sdr_bus_pkg::cmd_e                 cmd;
	sdr_bus_pkg::phase_t               phase;
	logic [sdr_bus_pkg::STEP_W-1:0]    last_step;
	logic                              last_byte;

	always_comb
	begin
		case (cmd)
			sdr_bus_pkg::CMD_GET_PARAMS:  last_step = sdr_bus_pkg::PARAM_BYTES - 1'b1;
			sdr_bus_pkg::CMD_SEND_STATUS: last_step = sdr_bus_pkg::STATUS_BYTES - 1'b1;
			sdr_bus_pkg::CMD_TX_IQ:       last_step = sdr_bus_pkg::TX_IQ_BYTES - 1'b1;
			sdr_bus_pkg::CMD_RX_IQ:       last_step = sdr_bus_pkg::RX_IQ_BYTES - 1'b1;
			default:                      last_step = '0; // Echo takes one byte
		endcase
	end

	assign last_byte  = (step == last_step);
	assign step_clear = bus_sync;

	// Write strobes are cut by a new sync
	assign param_wr = !bus_sync && phase == sdr_bus_pkg::PH_WRITE
		&& cmd == sdr_bus_pkg::CMD_GET_PARAMS;
	assign iq_wr    = !bus_sync && phase == sdr_bus_pkg::PH_WRITE
		&& cmd == sdr_bus_pkg::CMD_TX_IQ;

	// Read strobes already high in the sync cycle so blocks capture at the sync edge
	assign iq_rd     = bus_sync ? (bus_in == sdr_bus_pkg::CMD_RX_IQ)
		: (phase == sdr_bus_pkg::PH_READ && cmd == sdr_bus_pkg::CMD_RX_IQ);
	assign status_rd = bus_sync ? (bus_in == sdr_bus_pkg::CMD_SEND_STATUS)
		: (phase == sdr_bus_pkg::PH_READ && cmd == sdr_bus_pkg::CMD_SEND_STATUS);

	always_ff @(posedge IQ_valid)
	begin
		if (ADC_MINMAX_RESET)
		begin
			cmd                 <= sdr_bus_pkg::CMD_BUS_TEST;
			phase               <= sdr_bus_pkg::PH_IDLE;
			bus_out             <= '0;
			bus_oe              <= 1'b0;
			audio_clk_en        <= 1'b1;
			flash_enable        <= 1'b0;
			flash_continue_read <= 1'b0;
		end
		else
		begin
			flash_continue_read <= 1'b0; // One cycle pulse
			if (bus_sync)
			begin
				cmd          <= sdr_bus_pkg::cmd_e'(bus_in);
				bus_oe       <= 1'b0;
				flash_enable <= 1'b0;
				case (bus_in)
					sdr_bus_pkg::CMD_BUS_TEST,
					sdr_bus_pkg::CMD_GET_PARAMS,
					sdr_bus_pkg::CMD_TX_IQ:
					begin
						phase <= sdr_bus_pkg::PH_WRITE;
					end
					sdr_bus_pkg::CMD_SEND_STATUS,
					sdr_bus_pkg::CMD_RX_IQ:
					begin
						phase  <= sdr_bus_pkg::PH_READ;
						bus_oe <= 1'b1; // Master reads from next cycle
					end
					sdr_bus_pkg::CMD_AUDIO_ON:
					begin
						audio_clk_en <= 1'b1;
						phase        <= sdr_bus_pkg::PH_IDLE;
					end
					sdr_bus_pkg::CMD_AUDIO_OFF:
					begin
						audio_clk_en <= 1'b0;
						phase        <= sdr_bus_pkg::PH_IDLE;
					end
					sdr_bus_pkg::CMD_FLASH_READ:
					begin
						phase <= sdr_bus_pkg::PH_FLASH;
					end
					default:
					begin
						phase <= sdr_bus_pkg::PH_IDLE; // Unknown code
					end
				endcase
			end
			else
			begin
				case (phase)
					sdr_bus_pkg::PH_WRITE:
					begin
						if (cmd == sdr_bus_pkg::CMD_BUS_TEST)
						begin
							bus_out <= bus_in; // Echo held until next sync
							bus_oe  <= 1'b1;
						end
						if (last_byte)
						begin
							phase <= sdr_bus_pkg::PH_IDLE;
						end
					end
					sdr_bus_pkg::PH_READ:
					begin
						bus_out <= (cmd == sdr_bus_pkg::CMD_RX_IQ) ? iq_byte : status_byte;
						if (last_byte)
						begin
							phase <= sdr_bus_pkg::PH_IDLE;
						end
					end
					sdr_bus_pkg::PH_FLASH:
					begin
						if (!flash_enable)
						begin
							flash_cmd_byte <= bus_in; // First byte after sync
							flash_enable   <= 1'b1;
						end
						else if (step[0])
						begin
							bus_oe              <= 1'b1;
							bus_out             <= flash_busy ? sdr_bus_pkg::FLASH_BUSY_BYTE
								: flash_data_in;
							flash_continue_read <= !flash_busy;
						end
					end
					default:
					begin
						phase <= sdr_bus_pkg::PH_IDLE;
					end
				endcase
			end
		end
	end

endmodule

// ==== source/bus_step_counter.sv ====
module bus_step_counter
(
	input  logic                           IQ_valid,
	input  logic                           ADC_MINMAX_RESET,
	input  logic                           clear,
	output logic [sdr_bus_pkg::STEP_W-1:0] step
);

	// Byte index within the current command
	always_ff @(posedge IQ_valid)
	begin
		if (ADC_MINMAX_RESET)
		begin
			step <= '0;
		end
		else if (clear)
		begin
			step <= '0; // Restart on every sync
		end
		else
		begin
			step <= step + 1'b1; // Wraps at the top
		end
	end

endmodule

// ==== source/iq_exchange.sv ====
module iq_exchange
(
	input  logic                           IQ_valid,
	input  logic                           ADC_MINMAX_RESET,
	input  sdr_bus_pkg::iq_pair_t          spec_iq,
	input  sdr_bus_pkg::iq_pair_t          voice_iq,
	input  logic                           iq_wr,
	input  logic                           iq_rd,
	input  logic [sdr_bus_pkg::STEP_W-1:0] step,
	input  logic [7:0]                     bus_in,
	output sdr_bus_pkg::iq_pair_t          tx_iq,
	output logic [7:0]                     iq_byte
);

	sdr_bus_pkg::iq_word_u spec_hold;
	sdr_bus_pkg::iq_word_u voice_hold;
	sdr_bus_pkg::iq_word_u tx_hold;
	sdr_bus_pkg::iq_word_u tx_next;
	sdr_bus_pkg::iq_word_u rd_word;
	logic                  rd_q;

	// Freeze both receive pairs at the sync edge
	always_ff @(posedge IQ_valid)
	begin
		if (ADC_MINMAX_RESET)
		begin
			rd_q <= 1'b0;
		end
		else
		begin
			rd_q <= iq_rd;
		end
	end

	always_ff @(posedge IQ_valid)
	begin
		if (iq_rd && !rd_q)
		begin
			spec_hold.pair  <= spec_iq;
			voice_hold.pair <= voice_iq;
		end
	end

	assign rd_word = step[2] ? voice_hold : spec_hold; // Spectrum first, then voice
	assign iq_byte = rd_word.bytes[step[1:0]];

	// Last transmit byte completes the word
	always_comb
	begin
		tx_next          = tx_hold;
		tx_next.bytes[3] = bus_in;
	end

	always_ff @(posedge IQ_valid)
	begin
		if (iq_wr)
		begin
			tx_hold.bytes[step[1:0]] <= bus_in;
		end
	end

	always_ff @(posedge IQ_valid)
	begin
		if (ADC_MINMAX_RESET)
		begin
			tx_iq <= '0;
		end
		else if (iq_wr && step == sdr_bus_pkg::TX_IQ_BYTES - 1'b1)
		begin
			tx_iq <= tx_next.pair; // Whole pair in one step
		end
	end

endmodule

// ==== source/radio_param_regs.sv ====
module radio_param_regs
(
	input  logic                           IQ_valid,
	input  logic                           ADC_MINMAX_RESET,
	input  logic                           param_wr,
	input  logic [sdr_bus_pkg::STEP_W-1:0] step,
	input  logic [7:0]                     bus_in,
	output sdr_bus_pkg::radio_cfg_t        radio_cfg
);

	always_ff @(posedge IQ_valid)
	begin
		if (ADC_MINMAX_RESET)
		begin
			radio_cfg.pga         <= 1'b0;
			radio_cfg.rand_en     <= 1'b0;
			radio_cfg.shdn        <= 1'b0;
			radio_cfg.dith        <= 1'b0;
			radio_cfg.preamp      <= 1'b0;
			radio_cfg.tx          <= 1'b0;
			radio_cfg.freq        <= sdr_bus_pkg::FREQ_RESET;
			radio_cfg.cic_gain    <= sdr_bus_pkg::GAIN_RESET;
			radio_cfg.cicfir_gain <= sdr_bus_pkg::GAIN_RESET;
		end
		else if (param_wr)
		begin
			case (step)
				4'd0:
				begin
					radio_cfg.pga     <= bus_in[5];
					radio_cfg.rand_en <= bus_in[4];
					radio_cfg.shdn    <= bus_in[3];
					radio_cfg.dith    <= bus_in[2];
					radio_cfg.preamp  <= bus_in[1];
					radio_cfg.tx      <= bus_in[0];
				end
				4'd1:
				begin
					radio_cfg.freq[21:16] <= bus_in[5:0]; // Top two bits ignored
				end
				4'd2:
				begin
					radio_cfg.freq[15:8] <= bus_in;
				end
				4'd3:
				begin
					radio_cfg.freq[7:0] <= bus_in;
				end
				4'd4:
				begin
					radio_cfg.cic_gain <= bus_in;
				end
				4'd5:
				begin
					radio_cfg.cicfir_gain <= bus_in;
				end
				default:
				begin
					radio_cfg <= radio_cfg;
				end
			endcase
		end
	end

endmodule

// ==== source/sdr_bus_pkg.sv ====
package sdr_bus_pkg;

	// Command codes as sent by the microcontroller
	typedef enum logic [7:0]
	{
		CMD_BUS_TEST    = 8'd0,
		CMD_GET_PARAMS  = 8'd1,
		CMD_SEND_STATUS = 8'd2,
		CMD_TX_IQ       = 8'd3,
		CMD_RX_IQ       = 8'd4,
		CMD_AUDIO_ON    = 8'd5,
		CMD_AUDIO_OFF   = 8'd6,
		CMD_FLASH_READ  = 8'd7
	} cmd_e;

	localparam int STEP_W = 4;

	// Data bytes after the sync
	localparam logic [STEP_W-1:0] PARAM_BYTES  = 4'd6;
	localparam logic [STEP_W-1:0] STATUS_BYTES = 4'd5;
	localparam logic [STEP_W-1:0] TX_IQ_BYTES  = 4'd4;
	localparam logic [STEP_W-1:0] RX_IQ_BYTES  = 4'd8;

	localparam logic [21:0] FREQ_RESET = 22'd242347;
	localparam logic [7:0]  GAIN_RESET = 8'd32;

	localparam logic signed [15:0] PEAK_MIN_INIT = 16'sd2000;
	localparam logic signed [15:0] PEAK_MAX_INIT = -16'sd2000;

	localparam logic [7:0] FLASH_BUSY_BYTE = 8'hFF;

	typedef struct packed
	{
		logic signed [15:0] q;
		logic signed [15:0] i;
	} iq_pair_t;

	// Same word seen as a sample pair or in bus byte order
	typedef union packed
	{
		iq_pair_t         pair;
		logic [0:3][7:0]  bytes; // Q hi, Q lo, I hi, I lo
	} iq_word_u;

	typedef struct packed
	{
		logic        pga;
		logic        rand_en; // ADC randomizer
		logic        shdn;
		logic        dith;
		logic        preamp;
		logic        tx;
		logic [21:0] freq;
		logic [7:0]  cic_gain;
		logic [7:0]  cicfir_gain;
	} radio_cfg_t;

	typedef enum logic [1:0]
	{
		PH_IDLE,
		PH_WRITE,
		PH_READ,
		PH_FLASH
	} phase_t;

endpackage

// ==== source/sdr_bus_top.sv ====
module sdr_bus_top
(
	input  logic                    IQ_valid,
	input  logic                    ADC_MINMAX_RESET,
	input  logic                    bus_sync,
	input  logic [7:0]              bus_in,
	output logic [7:0]              bus_out,
	output logic                    bus_oe,
	input  sdr_bus_pkg::iq_pair_t   spec_iq,
	input  sdr_bus_pkg::iq_pair_t   voice_iq,
	input  logic signed [15:0]      adc_sample,
	input  logic                    adc_strobe,
	input  logic                    adc_otr,
	input  logic                    dac_otr,
	input  logic [7:0]              flash_data_in,
	input  logic                    flash_busy,
	output sdr_bus_pkg::radio_cfg_t radio_cfg,
	output sdr_bus_pkg::iq_pair_t   tx_iq,
	output logic                    audio_clk_en,
	output logic [7:0]              flash_cmd_byte,
	output logic                    flash_enable,
	output logic                    flash_continue_read
);

	logic [sdr_bus_pkg::STEP_W-1:0] step;
	logic                           step_clear;
	logic                           param_wr;
	logic                           iq_wr;
	logic                           iq_rd;
	logic                           status_rd;
	logic [7:0]                     iq_byte;
	logic [7:0]                     status_byte;

	bus_step_counter u_step
	(
		.IQ_valid         (IQ_valid),
		.ADC_MINMAX_RESET (ADC_MINMAX_RESET),
		.clear            (step_clear),
		.step             (step)
	);

	bus_cmd_fsm u_fsm
	(
		.IQ_valid            (IQ_valid),
		.ADC_MINMAX_RESET    (ADC_MINMAX_RESET),
		.bus_sync            (bus_sync),
		.bus_in              (bus_in),
		.step                (step),
		.iq_byte             (iq_byte),
		.status_byte         (status_byte),
		.flash_data_in       (flash_data_in),
		.flash_busy          (flash_busy),
		.step_clear          (step_clear),
		.param_wr            (param_wr),
		.iq_wr               (iq_wr),
		.iq_rd               (iq_rd),
		.status_rd           (status_rd),
		.bus_out             (bus_out),
		.bus_oe              (bus_oe),
		.audio_clk_en        (audio_clk_en),
		.flash_cmd_byte      (flash_cmd_byte),
		.flash_enable        (flash_enable),
		.flash_continue_read (flash_continue_read)
	);

	radio_param_regs u_params
	(
		.IQ_valid         (IQ_valid),
		.ADC_MINMAX_RESET (ADC_MINMAX_RESET),
		.param_wr         (param_wr),
		.step             (step),
		.bus_in           (bus_in),
		.radio_cfg        (radio_cfg)
	);

	adc_peak_tracker u_peak
	(
		.IQ_valid         (IQ_valid),
		.ADC_MINMAX_RESET (ADC_MINMAX_RESET),
		.adc_sample       (adc_sample),
		.adc_strobe       (adc_strobe),
		.adc_otr          (adc_otr),
		.dac_otr          (dac_otr),
		.status_rd        (status_rd),
		.step             (step),
		.status_byte      (status_byte)
	);

	iq_exchange u_iq
	(
		.IQ_valid         (IQ_valid),
		.ADC_MINMAX_RESET (ADC_MINMAX_RESET),
		.spec_iq          (spec_iq),
		.voice_iq         (voice_iq),
		.iq_wr            (iq_wr),
		.iq_rd            (iq_rd),
		.step             (step),
		.bus_in           (bus_in),
		.tx_iq            (tx_iq),
		.iq_byte          (iq_byte)
	);

endmodule
